//--- rtl/aluUnit.sv
/*
  Combinational ALU for add, sub, and, or, sll, sra
  Shifts use the shamt field and ignore opB
  neq and lt always compare opA against opB as signed, whatever the op
  Unknown op codes give a zero result
*/
module aluUnit (
    input  logic [cpuPkg::DATA_W-1:0]  opA,
    input  logic [cpuPkg::DATA_W-1:0]  opB,
    input  cpuPkg::aluOp_e             op,
    input  logic [cpuPkg::SHAMT_W-1:0] shamt,
    output logic [cpuPkg::DATA_W-1:0]  result,
    output cpuPkg::aluFlags_t          flags
);

    logic [cpuPkg::DATA_W-1:0] sum;
    logic [cpuPkg::DATA_W-1:0] diff;
    logic                      addOvf;
    logic                      subOvf;

    localparam int MSB = cpuPkg::DATA_W - 1;

    assign sum  = opA + opB;
    assign diff = opA - opB;

    // Same signs in, different sign out
    assign addOvf = (opA[MSB] == opB[MSB]) && (sum[MSB] != opA[MSB]);
    // Signs differ and result flips away from opA
    assign subOvf = (opA[MSB] != opB[MSB]) && (diff[MSB] != opA[MSB]);

    always_comb begin
        case (op)
            cpuPkg::ADD: result = sum;
            cpuPkg::SUB: result = diff;
            cpuPkg::AND: result = opA & opB;
            cpuPkg::OR:  result = opA | opB;
            cpuPkg::SLL: result = opA << shamt;
            cpuPkg::SRA: result = $signed(opA) >>> shamt;  // Sign fill
            default:     result = '0;
        endcase
    end

    assign flags.neq      = (opA != opB);
    assign flags.lt       = ($signed(opA) < $signed(opB));
    assign flags.overflow = ((op == cpuPkg::ADD) && addOvf) ||
                            ((op == cpuPkg::SUB) && subOvf);

endmodule

//--- rtl/cpuCore.sv
/*
  Top of the in-order core, structure only
  Instruction and data memories sit outside and answer one cycle after the address
  regWrite is the commit bus, dmemReq.we marks a committed store
*/
module cpuCore (
    input  logic                       clock,
    input  logic                       rst,
    input  logic [cpuPkg::DATA_W-1:0]  imemData,
    input  logic [cpuPkg::DATA_W-1:0]  dmemRdData,
    output logic [cpuPkg::PC_W-1:0]    imemAddr,
    output cpuPkg::storeReq_t          dmemReq,
    output cpuPkg::regWrite_t          regWrite
);

    // Fetch side
    logic                          hasSpace;
    logic                          pushValid;
    cpuPkg::fetchEntry_t           pushEntry;
    // Queue head handshake
    logic                          headValid;
    logic                          popReady;
    cpuPkg::fetchEntry_t           headEntry;
    // Taken branch or jump, also flushes the queue
    logic                          redirectValid;
    logic [cpuPkg::PC_W-1:0]       redirectPc;
    // Register file and ALU
    logic [cpuPkg::REG_ADDR_W-1:0] rdAddrA;
    logic [cpuPkg::REG_ADDR_W-1:0] rdAddrB;
    logic [cpuPkg::DATA_W-1:0]     rdDataA;
    logic [cpuPkg::DATA_W-1:0]     rdDataB;
    logic [cpuPkg::DATA_W-1:0]     aluA;
    logic [cpuPkg::DATA_W-1:0]     aluB;
    cpuPkg::aluOp_e                aluOp;
    logic [cpuPkg::SHAMT_W-1:0]    shamt;
    logic [cpuPkg::DATA_W-1:0]     aluResult;
    cpuPkg::aluFlags_t             aluFlags;

    fetchUnit fetchUnit_i (
        .clock(clock), .rst(rst), .hasSpace(hasSpace),
        .redirectValid(redirectValid), .redirectPc(redirectPc), .imemData(imemData),
        .imemAddr(imemAddr), .pushValid(pushValid), .pushEntry(pushEntry)
    );

    fetchQueue fetchQueue_i (
        .clock(clock), .rst(rst), .pushValid(pushValid), .pushEntry(pushEntry),
        .popReady(popReady), .flush(redirectValid), .hasSpace(hasSpace),
        .headValid(headValid), .headEntry(headEntry)
    );

    executeUnit executeUnit_i (
        .clock(clock), .rst(rst), .headValid(headValid), .headEntry(headEntry),
        .rdDataA(rdDataA), .rdDataB(rdDataB), .aluResult(aluResult),
        .aluFlags(aluFlags), .dmemRdData(dmemRdData), .popReady(popReady),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .aluA(aluA), .aluB(aluB),
        .aluOp(aluOp), .shamt(shamt), .regWrite(regWrite), .dmemReq(dmemReq)
    );

    regFile regFile_i (
        .clock(clock), .rst(rst), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .wr(regWrite), .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    aluUnit aluUnit_i (
        .opA(aluA), .opB(aluB), .op(aluOp), .shamt(shamt),
        .result(aluResult), .flags(aluFlags)
    );

endmodule

//--- rtl/cpuPkg.sv
/*
  Shared widths, encodings and bus structs for the single-stage core
  Opcode and ALU-op values follow the reference instruction format
  Instruction memory is word addressed with PC_W bits, so programs stay under 4K words
  QUEUE_DEPTH must be a power of two since the queue pointers wrap freely
*/
package cpuPkg;

    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 2 ** REG_ADDR_W;
    localparam int PC_W        = 12;          // Instruction word address
    localparam int OPCODE_W    = 5;
    localparam int SHAMT_W     = 5;
    localparam int IMM_W       = 17;          // Sign-extended immediate field
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

    // Overflow exception target and status codes
    localparam logic [REG_ADDR_W-1:0] STATUS_REG = 5'd30;
    localparam logic [DATA_W-1:0] EXC_ADD  = 32'd1;
    localparam logic [DATA_W-1:0] EXC_ADDI = 32'd2;
    localparam logic [DATA_W-1:0] EXC_SUB  = 32'd3;

    typedef enum logic [OPCODE_W-1:0] {
        ALU_R = 5'd0,
        J     = 5'd1,
        BNE   = 5'd2,
        ADDI  = 5'd5,
        BLT   = 5'd6,
        SW    = 5'd7,
        LW    = 5'd8
    } opcode_e;

    typedef enum logic [4:0] {
        ADD = 5'd0,
        SUB = 5'd1,
        AND = 5'd2,
        OR  = 5'd3,
        SLL = 5'd4,
        SRA = 5'd5
    } aluOp_e;

    typedef enum logic {
        EXEC,
        LOAD_WAIT          // Load data returns this cycle
    } execState_e;

    // Fetched word tagged with its own address
    typedef struct packed {
        logic [PC_W-1:0]   pc;
        logic [DATA_W-1:0] instr;
    } fetchEntry_t;

    // Commit bus into the register file
    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } regWrite_t;

    // Data memory request, address also used for loads
    typedef struct packed {
        logic              we;
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } storeReq_t;

    typedef struct packed {
        logic neq;
        logic lt;        // Signed opA < opB
        logic overflow;  // ADD and SUB only
    } aluFlags_t;

endpackage

//--- rtl/executeUnit.sv
/*
  Single-stage decode, execute, memory and writeback of the queue head
  Everything but lw finishes in the head cycle, lw adds one LOAD_WAIT cycle
  Branches compare rd against rs and go to pc + 1 + imm, j goes to target[PC_W-1:0]
  Writes to r0 show zero data on the commit bus
  Unknown opcodes are popped without any effect
*/
module executeUnit (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          headValid,
    input  cpuPkg::fetchEntry_t           headEntry,
    input  logic [cpuPkg::DATA_W-1:0]     rdDataA,
    input  logic [cpuPkg::DATA_W-1:0]     rdDataB,
    input  logic [cpuPkg::DATA_W-1:0]     aluResult,
    input  cpuPkg::aluFlags_t             aluFlags,
    input  logic [cpuPkg::DATA_W-1:0]     dmemRdData,
    output logic                          popReady,
    output logic                          redirectValid,
    output logic [cpuPkg::PC_W-1:0]       redirectPc,
    output logic [cpuPkg::REG_ADDR_W-1:0] rdAddrA,
    output logic [cpuPkg::REG_ADDR_W-1:0] rdAddrB,
    output logic [cpuPkg::DATA_W-1:0]     aluA,
    output logic [cpuPkg::DATA_W-1:0]     aluB,
    output cpuPkg::aluOp_e                aluOp,
    output logic [cpuPkg::SHAMT_W-1:0]    shamt,
    output cpuPkg::regWrite_t             regWrite,
    output cpuPkg::storeReq_t             dmemReq
);

    localparam int DW = cpuPkg::DATA_W;
    localparam int IW = cpuPkg::IMM_W;

    cpuPkg::opcode_e               opcode;
    cpuPkg::execState_e            state;
    logic [cpuPkg::REG_ADDR_W-1:0] rd;
    logic [cpuPkg::REG_ADDR_W-1:0] rs;
    logic [cpuPkg::REG_ADDR_W-1:0] rt;
    logic [DW-1:0]                 imm;
    logic [cpuPkg::PC_W-1:0]       branchTarget;
    logic [cpuPkg::PC_W-1:0]       jumpTarget;
    logic                          execCycle;  // Head is live and not waiting on a load
    logic                          wbEn;
    logic [cpuPkg::REG_ADDR_W-1:0] wbAddr;
    logic [DW-1:0]                 wbData;

    // Field extraction
    assign opcode = cpuPkg::opcode_e'(headEntry.instr[31:27]);
    assign rd     = headEntry.instr[26:22];
    assign rs     = headEntry.instr[21:17];
    assign rt     = headEntry.instr[16:12];
    assign shamt  = headEntry.instr[11:7];
    assign imm    = {{(DW - IW){headEntry.instr[IW-1]}}, headEntry.instr[IW-1:0]};

    assign jumpTarget   = headEntry.instr[cpuPkg::PC_W-1:0];  // Upper target bits unused
    assign branchTarget = headEntry.pc + 1'b1 + imm[cpuPkg::PC_W-1:0];

    assign execCycle = headValid && (state == cpuPkg::EXEC);

    // Register reads and ALU operand select
    always_comb begin
        rdAddrA = rs;
        rdAddrB = rt;
        aluA    = rdDataA;
        aluB    = rdDataB;
        aluOp   = cpuPkg::ADD;  // Address and addi default
        case (opcode)
            cpuPkg::ALU_R: aluOp = cpuPkg::aluOp_e'(headEntry.instr[6:2]);
            cpuPkg::ADDI,
            cpuPkg::LW:    aluB = imm;
            cpuPkg::SW: begin
                rdAddrB = rd;   // Store data comes from rd
                aluB    = imm;
            end
            cpuPkg::BNE,
            cpuPkg::BLT: begin
                rdAddrA = rd;   // Compare rd against rs
                rdAddrB = rs;
                aluOp   = cpuPkg::SUB;
            end
            default: ;
        endcase
    end

    // Writeback select with overflow redirect to the status register
    always_comb begin
        wbEn   = 1'b0;
        wbAddr = rd;
        wbData = aluResult;
        case (opcode)
            cpuPkg::ALU_R: begin
                wbEn = execCycle;
                if (aluFlags.overflow) begin  // Only ADD or SUB can set it
                    wbAddr = cpuPkg::STATUS_REG;
                    wbData = (aluOp == cpuPkg::SUB) ? cpuPkg::EXC_SUB : cpuPkg::EXC_ADD;
                end
            end
            cpuPkg::ADDI: begin
                wbEn = execCycle;
                if (aluFlags.overflow) begin
                    wbAddr = cpuPkg::STATUS_REG;
                    wbData = cpuPkg::EXC_ADDI;
                end
            end
            cpuPkg::LW: begin
                wbEn   = headValid && (state == cpuPkg::LOAD_WAIT);
                wbData = dmemRdData;
            end
            default: ;
        endcase
    end

    assign regWrite.en   = wbEn;
    assign regWrite.addr = wbAddr;
    assign regWrite.data = (wbAddr == '0) ? '0 : wbData;

    // Load address is held through LOAD_WAIT, harmless for the read
    assign dmemReq.we   = execCycle && (opcode == cpuPkg::SW);
    assign dmemReq.addr = aluResult;  // rs + imm
    assign dmemReq.data = rdDataB;

    assign redirectValid = execCycle && ((opcode == cpuPkg::J) ||
                           ((opcode == cpuPkg::BNE) && aluFlags.neq) ||
                           ((opcode == cpuPkg::BLT) && aluFlags.lt));
    assign redirectPc    = (opcode == cpuPkg::J) ? jumpTarget : branchTarget;

    // A load stays at the head until its data is back
    assign popReady = (state == cpuPkg::LOAD_WAIT) || (opcode != cpuPkg::LW);

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= cpuPkg::EXEC;
        end else begin
            case (state)
                cpuPkg::EXEC: begin
                    if (headValid && (opcode == cpuPkg::LW)) begin
                        state <= cpuPkg::LOAD_WAIT;
                    end
                end
                cpuPkg::LOAD_WAIT: state <= cpuPkg::EXEC;  // Always one cycle
                default:           state <= cpuPkg::EXEC;
            endcase
        end
    end

endmodule

//--- rtl/fetchQueue.sv
/*
  Circular buffer of fetched instructions between fetch and execute
  Pushes carry no ready, the fetch unit relies on hasSpace as a credit
  hasSpace needs two free slots so one request in flight always fits
  Flush wins over a push or pop in the same cycle
*/
module fetchQueue (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 pushValid,
    input  cpuPkg::fetchEntry_t  pushEntry,
    input  logic                 popReady,
    input  logic                 flush,
    output logic                 hasSpace,
    output logic                 headValid,
    output cpuPkg::fetchEntry_t  headEntry
);

    cpuPkg::fetchEntry_t         mem [cpuPkg::QUEUE_DEPTH];
    logic [cpuPkg::QPTR_W-1:0]   wrPtr;
    logic [cpuPkg::QPTR_W-1:0]   rdPtr;
    logic [cpuPkg::QPTR_W:0]     count;   // One extra bit to hold full
    logic                        pop;

    assign pop = headValid && popReady;

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            wrPtr <= '0;  // Realign both pointers to slot 0
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= wrPtr + 1'b1;  // Wraps at depth
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({pushValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Storage only
    always_ff @(posedge clock) begin
        if (pushValid) begin
            mem[wrPtr] <= pushEntry;
        end
    end

    assign headValid = (count != '0);
    assign headEntry = mem[rdPtr];
    assign hasSpace  = (count <= (cpuPkg::QUEUE_DEPTH - 2));

endmodule

//--- rtl/fetchUnit.sv
/*
  Program counter and instruction memory requests
  Memory answers one cycle after the address, the word is pushed without a handshake
  An address is issued only while the queue reports room for two words
  A redirect drops the response of the address issued in that same cycle
*/
module fetchUnit (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       hasSpace,
    input  logic                       redirectValid,
    input  logic [cpuPkg::PC_W-1:0]    redirectPc,
    input  logic [cpuPkg::DATA_W-1:0]  imemData,
    output logic [cpuPkg::PC_W-1:0]    imemAddr,
    output logic                       pushValid,
    output cpuPkg::fetchEntry_t        pushEntry
);

    logic [cpuPkg::PC_W-1:0] pc;
    logic [cpuPkg::PC_W-1:0] inFlightPc;  // Address of the word now returning
    logic                    inFlight;
    logic                    issue;

    // No new request on a redirect cycle, its word would be stale anyway
    assign issue    = hasSpace && !redirectValid;
    assign imemAddr = pc;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc       <= '0;   // First request goes to word 0
            inFlight <= 1'b0;
        end else begin
            inFlight <= issue;  // Cleared by redirect through issue
            if (redirectValid) begin
                pc <= redirectPc;
            end else if (issue) begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Tag only, meaningful while inFlight is set
    always_ff @(posedge clock) begin
        inFlightPc <= pc;
    end

    // Slot was reserved at issue time
    assign pushValid       = inFlight;
    assign pushEntry.pc    = inFlightPc;
    assign pushEntry.instr = imemData;

endmodule

//--- rtl/regFile.sv
/*
  32 x 32 register file with two combinational read ports
  Single write port on the rising edge
  Register 0 ignores writes and always reads as zero
*/
module regFile (
    input  logic                          clock,
    input  logic                          rst,
    input  logic [cpuPkg::REG_ADDR_W-1:0] rdAddrA,
    input  logic [cpuPkg::REG_ADDR_W-1:0] rdAddrB,
    input  cpuPkg::regWrite_t             wr,
    output logic [cpuPkg::DATA_W-1:0]     rdDataA,
    output logic [cpuPkg::DATA_W-1:0]     rdDataB
);

    logic [cpuPkg::DATA_W-1:0] regs [cpuPkg::NUM_REGS];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // Write in this cycle is seen next cycle, no internal forwarding
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- sim.f
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/fetchQueue.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/executeUnit.sv
rtl/cpuCore.sv
testbench/cpuCore_chk.sv
testbench/cpuCoreTb.sv

//--- testbench/cpuCoreTb.sv
/*
  Random programs against an in-order ISA model of the core
  Loads and stores use r0 as base, so data addresses stay in a 64-word window
  A program is a random body, a run of zero words, then a jump to itself as the stop
  Branches and jumps only go forward, so every program ends
*/
module cpuCoreTb;

    localparam int BODY_LEN   = 48;
    localparam int PROG_LEN   = BODY_LEN + 6;   // Body plus zero-word run
    localparam int IMEM_WORDS = 2 ** cpuPkg::PC_W;
    localparam int DMEM_WORDS = 64;
    localparam int QUIET      = 16;             // Idle cycles that must stay commit free

    logic                      clock;
    logic                      rst;
    logic [cpuPkg::DATA_W-1:0] imemData;
    logic [cpuPkg::DATA_W-1:0] dmemRdData;
    logic [cpuPkg::PC_W-1:0]   imemAddr;
    cpuPkg::storeReq_t         dmemReq;
    cpuPkg::regWrite_t         regWrite;

    logic [31:0]       imem [IMEM_WORDS];
    logic [31:0]       dmem [DMEM_WORDS];
    logic [31:0]       dmemInit [DMEM_WORDS];  // Contents at program start
    cpuPkg::regWrite_t expWrites [$];
    cpuPkg::storeReq_t expStores [$];

    integer seed = 55;
    int     errCount = 0;
    int     passCount = 0;
    int     failCount = 0;
    int     cycleCount = 0;
    int     deadline = 0;     // Zero while no test runs
    bit     checking = 1'b0;
    bit     rstPrev = 1'b1;
    string  testName = "";

    cpuCore cpuCore_i (
        .clock(clock), .rst(rst), .imemData(imemData), .dmemRdData(dmemRdData),
        .imemAddr(imemAddr), .dmemReq(dmemReq), .regWrite(regWrite)
    );

    always #4 clock = ~clock;

    // Both memories answer one cycle after the address
    always @(posedge clock) begin
        imemData   <= imem[imemAddr];
        dmemRdData <= dmem[dmemReq.addr[5:0]];
        if (dmemReq.we) begin
            dmem[dmemReq.addr[5:0]] <= dmemReq.data;
        end
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if ((deadline > 0) && (cycleCount > deadline)) begin
            $display("Timeout in test %s, program not finished by cycle %0d", testName, deadline);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Commits sampled mid-cycle where they are stable
    always @(negedge clock) begin
        if (rst && rstPrev && (regWrite.en || dmemReq.we)) begin
            $display("Commit seen during reset at time %0t in test %s", $time, testName);
            errCount++;
        end
        if (!rst && checking) begin
            if (regWrite.en) begin
                checkRegWrite(regWrite);
            end
            if (dmemReq.we) begin
                checkStore(dmemReq);
            end
        end
        rstPrev = rst;
    end

    task automatic checkRegWrite(input cpuPkg::regWrite_t got);
        cpuPkg::regWrite_t exp;
        if (expWrites.size() == 0) begin
            $display("Extra register write to r%0d at time %0t", got.addr, $time);
            errCount++;
        end else begin
            exp = expWrites.pop_front();
            if (got !== exp) begin
                $display("FAIL %0t: write r%0d = %h, expected r%0d = %h",
                         $time, got.addr, got.data, exp.addr, exp.data);
                errCount++;
            end
        end
    endtask

    task automatic checkStore(input cpuPkg::storeReq_t got);
        cpuPkg::storeReq_t exp;
        if (expStores.size() == 0) begin
            $display("Extra store to address %h at time %0t", got.addr, $time);
            errCount++;
        end else begin
            exp = expStores.pop_front();
            if (got !== exp) begin
                $display("FAIL %0t: store [%h] = %h, expected [%h] = %h",
                         $time, got.addr, got.data, exp.addr, exp.data);
                errCount++;
            end
        end
    endtask

    function automatic int unsigned rnd(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] rType(cpuPkg::aluOp_e op, int rd, int rs, int rt, int sh);
        return {cpuPkg::ALU_R, 5'(rd), 5'(rs), 5'(rt), 5'(sh), op, 2'b00};
    endfunction

    function automatic logic [31:0] iType(cpuPkg::opcode_e op, int rd, int rs, int imm);
        return {op, 5'(rd), 5'(rs), 17'(imm)};
    endfunction

    function automatic logic [31:0] jType(int target);
        return {cpuPkg::J, 27'(target)};
    endfunction

    // Full sum does not fit in 32 signed bits
    function automatic bit overflows(longint wide);
        return wide != longint'($signed(wide[31:0]));
    endfunction

    // Mode 0 ALU, 1 overflow, 2 memory, 3 branches, 4 everything
    function automatic logic [31:0] genInstr(int mode, int pc);
        int unsigned pick;
        int          rd;
        int          rs;
        int          rt;
        int          skip;
        logic [31:0] word;
        pick = rnd(10);
        rd   = rnd(16);  // r0 included, its writes commit zero data
        rs   = rnd(16);
        rt   = rnd(16);
        skip = rnd(4);
        if (pc + 1 + skip > BODY_LEN) begin
            skip = BODY_LEN - pc - 1;  // Land in the zero run at most
        end
        word = rType(cpuPkg::aluOp_e'(rnd(6)), rd, rs, rt, rnd(32));
        if (pc < 8) begin
            word = iType(cpuPkg::ADDI, pc + 1, 0, rnd(2 ** 17));  // Seed r1 to r8
        end else if (mode == 1) begin
            case (pick)
                0, 1, 2: word = iType(cpuPkg::ADDI, rd, rs, rnd(2 ** 17));
                3, 4:    word = rType(cpuPkg::SLL, rd, rs, 0, 24 + rnd(8));  // Big values
                5, 6:    word = rType(cpuPkg::SUB, rd, rs, rt, 0);
                default: word = rType(cpuPkg::ADD, rd, rs, rt, 0);
            endcase
        end else if ((mode == 2 || mode == 4) && pick < 5) begin
            if (pick < 3) begin
                word = iType(cpuPkg::LW, rd, 0, rnd(DMEM_WORDS));  // Load runs fill the queue
            end else begin
                word = iType(cpuPkg::SW, rd, 0, rnd(DMEM_WORDS));
            end
        end else if ((mode == 3 || mode == 4) && pick >= 6) begin
            case (pick)
                6:       word = iType(cpuPkg::BNE, rd, rs, skip);
                7, 8:    word = iType(cpuPkg::BLT, rd, rs, skip);
                default: word = jType(pc + 1 + skip);
            endcase
        end
        return word;
    endfunction

    task automatic loadProgram(int mode);
        foreach (imem[i]) begin
            imem[i] = '0;  // Zero run and unused words
        end
        for (int pc = 0; pc < BODY_LEN; pc++) begin
            imem[pc] = genInstr(mode, pc);
        end
        imem[PROG_LEN] = jType(PROG_LEN);  // Stop loop, commits nothing
        foreach (dmemInit[i]) begin
            dmemInit[i] = $random(seed);
        end
    endtask

    // In-order ISA model, fills the expected commit lists
    task automatic runModel();
        logic [31:0]       regs [32];
        logic [31:0]       mem [DMEM_WORDS];
        logic [31:0]       ins;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       imm;
        logic [31:0]       val;
        logic [31:0]       addr;
        logic [4:0]        dest;
        longint            wide;
        int                pc;
        bit                wr;
        cpuPkg::regWrite_t w;
        cpuPkg::storeReq_t s;
        expWrites.delete();
        expStores.delete();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        mem = dmemInit;
        pc  = 0;
        while (pc < PROG_LEN) begin
            ins  = imem[pc];
            a    = regs[ins[21:17]];  // rs
            b    = regs[ins[16:12]];  // rt
            imm  = {{15{ins[16]}}, ins[16:0]};
            addr = a + imm;
            dest = ins[26:22];
            wr   = 1'b0;
            pc   = pc + 1;
            case (ins[31:27])
                cpuPkg::ALU_R: begin
                    wr = 1'b1;
                    if (ins[6:2] == cpuPkg::SUB) begin
                        wide = longint'($signed(a)) - longint'($signed(b));
                    end else begin
                        wide = longint'($signed(a)) + longint'($signed(b));
                    end
                    case (ins[6:2])
                        cpuPkg::AND: val = a & b;
                        cpuPkg::OR:  val = a | b;
                        cpuPkg::SLL: val = a << ins[11:7];
                        cpuPkg::SRA: val = $signed(a) >>> ins[11:7];
                        default:     val = wide[31:0];  // ADD or SUB
                    endcase
                    if ((ins[6:2] <= cpuPkg::SUB) && overflows(wide)) begin
                        dest = cpuPkg::STATUS_REG;  // rd left alone
                        val  = (ins[6:2] == cpuPkg::SUB) ? 32'd3 : 32'd1;
                    end
                end
                cpuPkg::ADDI: begin
                    wr   = 1'b1;
                    wide = longint'($signed(a)) + longint'($signed(imm));
                    val  = wide[31:0];
                    if (overflows(wide)) begin
                        dest = cpuPkg::STATUS_REG;
                        val  = 32'd2;
                    end
                end
                cpuPkg::LW: begin
                    wr  = 1'b1;
                    val = mem[addr[5:0]];
                end
                cpuPkg::SW: begin
                    mem[addr[5:0]] = regs[dest];
                    s.we   = 1'b1;
                    s.addr = addr;
                    s.data = regs[dest];
                    expStores.push_back(s);
                end
                cpuPkg::BNE: if (regs[dest] != a) pc = pc + $signed(imm);
                cpuPkg::BLT: if ($signed(regs[dest]) < $signed(a)) pc = pc + $signed(imm);
                cpuPkg::J:   pc = ins[26:0];
                default: ;
            endcase
            if (wr) begin
                w.en   = 1'b1;
                w.addr = dest;
                w.data = (dest == '0) ? '0 : val;  // r0 stays zero
                if (dest != '0) begin
                    regs[dest] = val;
                end
                expWrites.push_back(w);
            end
        end
    endtask

    // Five reset edges, data memory back to its start contents
    task automatic applyReset();
        @(posedge clock);
        rst <= 1'b1;
        repeat (2) @(posedge clock);
        dmem = dmemInit;
        repeat (3) @(posedge clock);
        rst <= 1'b0;
    endtask

    task automatic runTest(string name, int mode, bit midReset);
        int errStart;
        int chkStart;
        int half;
        errStart = errCount;
        chkStart = cpuCore_i.cpuCoreChk_i.failures;
        testName = name;
        checking = 1'b0;
        loadProgram(mode);
        runModel();
        half = expWrites.size() / 2;
        applyReset();
        if (midReset) begin
            deadline = cycleCount + 4 * (PROG_LEN + 1) + 200;
            checking = 1'b1;
            while (expWrites.size() > half) begin
                @(posedge clock);
            end
            checking = 1'b0;
            applyReset();  // Restart from word 0
            runModel();    // Same expected list again
        end
        deadline = cycleCount + 4 * (PROG_LEN + 1) + 200;
        checking = 1'b1;
        while (expWrites.size() > 0 || expStores.size() > 0) begin
            @(posedge clock);
        end
        repeat (QUIET) @(posedge clock);  // Catches extra commits
        checking = 1'b0;
        deadline = 0;
        errCount += cpuCore_i.cpuCoreChk_i.failures - chkStart;  // Bound assertion failures
        if (errCount == errStart) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("Test %s done with %0d errors", name, errCount - errStart);
    endtask

    initial begin
        clock      = 1'b0;
        rst        = 1'b1;
        imemData   = '0;
        dmemRdData = '0;
        runTest("aluRandom", 0, 1'b0);
        runTest("overflow", 1, 1'b0);
        runTest("loadStore", 2, 1'b0);
        runTest("branches", 3, 1'b0);
        runTest("midReset", 4, 1'b1);
        $display("Tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/cpuCore_chk.sv
/*
  Concurrent checks bound into every cpuCore instance
  Commit ports and the queue head are sampled on the rising clock
*/
module cpuCoreChk (
    input logic              clock,
    input logic              rst,
    input cpuPkg::regWrite_t regWrite,
    input cpuPkg::storeReq_t dmemReq,
    input logic              redirectValid,
    input logic              headValid
);

    int failures = 0;  // Failed assertions so far

    // r0 never carries data on the commit bus
    zeroRegData: assert property (@(posedge clock) disable iff (rst)
        (regWrite.en && (regWrite.addr == '0)) |-> (regWrite.data == '0))
        else begin
            $error("Nonzero data on a write to r0");
            failures++;
        end

    oneCommitKind: assert property (@(posedge clock) disable iff (rst)
        !(regWrite.en && dmemReq.we))  // A store never writes a register
        else begin
            $error("Register write and store in the same cycle");
            failures++;
        end

    // Flush empties the queue on the redirect edge
    emptyAfterFlush: assert property (@(posedge clock) disable iff (rst)
        redirectValid |=> !headValid)
        else begin
            $error("Queue head valid right after a flush");
            failures++;
        end

    idleAfterReset: assert property (@(posedge clock)
        $past(rst) |-> (!regWrite.en && !dmemReq.we))
        else begin
            $error("Commit enable high after a reset edge");
            failures++;
        end

endmodule

bind cpuCore cpuCoreChk cpuCoreChk_i (
    .clock(clock), .rst(rst), .regWrite(regWrite), .dmemReq(dmemReq),
    .redirectValid(redirectValid), .headValid(headValid)
);
